// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_dds_modulator
FILELIST  = dds_modulator.f
MDIR      = obj_dir
SIM       = $(MDIR)/V$(TOP)
SOURCES   = $(wildcard hw/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(MDIR)

// File: dds_modulator.f
+incdir+verif
hw/dds_pkg.sv
hw/dds_ctrl_if.sv
hw/modulation_control.sv
hw/phase_accumulator.sv
hw/wave_lookup.sv
hw/symbol_modulator.sv
hw/dds_modulator_top.sv
verif/tb_dds_modulator.sv

// File: hw/dds_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dds_ctrl_if import dds_pkg::*; ();

   phase_t phase_inc;    // step for the phase register
   logic   data_bit;     // current symbol bit
   mod_e   mode;         // registered modulation mode
   logic   symbol_tick;  // one cycle per symbol period

   modport ctrl (
      output phase_inc,
      output data_bit,
      output mode,
      output symbol_tick
   );

   modport accum (
      input phase_inc
   );

   modport modulate (
      input data_bit,
      input mode
   );

endinterface

`default_nettype wire

// File: hw/dds_modulator_top.sv
`timescale 1ns/10ps
`default_nettype none

module dds_modulator_top import dds_pkg::*; #(
   parameter int symbol_cycles = 16
) (
   input  wire logic         CLK_25MHZ,
   input  wire logic         reset_from_key,
   input  wire logic [31:0]  freq_word,
   input  wire logic [1:0]   wave_sel,
   input  wire logic [1:0]   mod_sel,
   output logic [11:0]       carrier_out,
   output logic [11:0]       modulated_out,
   output logic              data_bit,
   output logic              symbol_tick
);

   dds_ctrl_if ctrl_bus ();

   phase_t  phase;
   sample_t carrier;
   sample_t modulated;

   //////////////////// control
   modulation_control #(
      .symbol_cycles (symbol_cycles)
   ) modulation_control_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .freq_word      (phase_t'(freq_word)),
      .mod_sel        (mod_e'(mod_sel)),
      .ctrl           (ctrl_bus.ctrl)
   );

   //////////////////// datapath
   phase_accumulator phase_accumulator_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .ctrl           (ctrl_bus.accum),
      .phase          (phase)
   );

   wave_lookup wave_lookup_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase          (phase),
      .wave_sel       (wave_e'(wave_sel)),
      .carrier        (carrier)
   );

   symbol_modulator symbol_modulator_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .carrier        (carrier),
      .ctrl           (ctrl_bus.modulate),
      .modulated      (modulated)
   );

   //////////////////// outputs
   assign carrier_out   = carrier;
   assign modulated_out = modulated;
   assign data_bit      = ctrl_bus.data_bit;
   assign symbol_tick   = ctrl_bus.symbol_tick;

endmodule

`default_nettype wire

// File: hw/dds_pkg.sv
`default_nettype none

package dds_pkg;

   //////////////////// widths
   typedef logic [31:0] phase_t;          // phase and frequency word
   typedef logic signed [11:0] sample_t;  // two's complement sample

   localparam int lut_addr_bits = 6;      // top phase bits into the sine table
   localparam int cos_offset = 16;        // quarter period in table entries

   localparam sample_t full_scale = 12'sd2047;

   //////////////////// selectors
   typedef enum logic [1:0] {
      wave_sin,
      wave_cos,
      wave_saw,
      wave_square
   } wave_e;

   typedef enum logic [1:0] {
      mod_ask,
      mod_fsk,
      mod_bpsk,
      mod_lfsr
   } mod_e;

   //////////////////// lfsr for x^5 + x^3 + 1
   localparam logic [4:0] lfsr_seed = 5'b00001;
   localparam logic [4:0] lfsr_taps = 5'b10100;  // bit4 xor bit2

endpackage

`default_nettype wire

// File: hw/modulation_control.sv
`timescale 1ns/10ps
`default_nettype none

module modulation_control import dds_pkg::*; #(
   parameter int symbol_cycles = 16
) (
   input  wire logic    CLK_25MHZ,
   input  wire logic    reset_from_key,
   input  wire phase_t  freq_word,
   input  wire mod_e    mod_sel,
   dds_ctrl_if.ctrl     ctrl
);

   localparam int cnt_bits = (symbol_cycles > 1) ? $clog2(symbol_cycles) : 1;
   localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(symbol_cycles - 1);

   logic [cnt_bits-1:0] symbol_cnt;
   logic                tick_q;
   logic [4:0]          lfsr;
   logic                lfsr_fb;
   mod_e                mode_q;

   //////////////////// symbol timing
   // tick goes high on the edge that closes each period
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         symbol_cnt <= '0;
         tick_q     <= 1'b0;
      end
      else if (symbol_cnt == cnt_last)
      begin
         symbol_cnt <= '0;
         tick_q     <= 1'b1;
      end
      else
      begin
         symbol_cnt <= symbol_cnt + 1'b1;
         tick_q     <= 1'b0;
      end
   end

   //////////////////// data source
   assign lfsr_fb = ^(lfsr & lfsr_taps);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr <= lfsr_seed;
      else if (symbol_cnt == cnt_last)  // same edge as the tick
         lfsr <= {lfsr[3:0], lfsr_fb};
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         mode_q <= mod_ask;
      else
         mode_q <= mod_sel;
   end

   //////////////////// outputs
   assign ctrl.symbol_tick = tick_q;
   assign ctrl.data_bit    = lfsr[4];
   assign ctrl.mode        = mode_q;

   // a one bit doubles the carrier frequency in fsk
   always_comb
   begin
      if (mode_q == mod_fsk && lfsr[4])
         ctrl.phase_inc = freq_word << 1;
      else
         ctrl.phase_inc = freq_word;
   end

endmodule

`default_nettype wire

// File: hw/phase_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module phase_accumulator import dds_pkg::*; (
   input  wire logic   CLK_25MHZ,
   input  wire logic   reset_from_key,
   dds_ctrl_if.accum   ctrl,
   output phase_t      phase
);

   phase_t phase_q;

   // wraps modulo 2^32 on its own
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase_q <= '0;
      else
         phase_q <= phase_q + ctrl.phase_inc;
   end

   assign phase = phase_q;

endmodule

`default_nettype wire

// File: hw/sine_lut.hex
// one signed 12-bit sample per line, two's complement hex, index 0 to 63
000
0C9
18F
252
30F
3C5
471
513
5A7
62E
6A6
70D
763
7A7
7D8
7F5
7FF
7F5
7D8
7A7
763
70D
6A6
62E
5A7
513
471
3C5
30F
252
18F
0C9
000
F37
E71
DAE
CF1
C3B
B8F
AED
A59
9D2
95A
8F3
89D
859
828
80B
801
80B
828
859
89D
8F3
95A
9D2
A59
AED
B8F
C3B
CF1
DAE
E71
F37

// File: hw/symbol_modulator.sv
`timescale 1ns/10ps
`default_nettype none

module symbol_modulator import dds_pkg::*; (
   input  wire logic     CLK_25MHZ,
   input  wire logic     reset_from_key,
   input  wire sample_t  carrier,
   dds_ctrl_if.modulate  ctrl,
   output sample_t       modulated
);

   sample_t mod_next;
   sample_t mod_q;

   always_comb
   begin
      case (ctrl.mode)
         mod_ask:  mod_next = ctrl.data_bit ? carrier : '0;        // on/off keying
         mod_fsk:  mod_next = carrier;  // frequency already shifted upstream
         mod_bpsk: mod_next = ctrl.data_bit ? carrier : -carrier;
         mod_lfsr: mod_next = ctrl.data_bit ? full_scale : -full_scale;
         default:  mod_next = '0;
      endcase
   end

   // one register stage after the carrier
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         mod_q <= '0;
      else
         mod_q <= mod_next;
   end

   assign modulated = mod_q;

endmodule

`default_nettype wire

// File: hw/wave_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module wave_lookup import dds_pkg::*; (
   input  wire logic    CLK_25MHZ,
   input  wire logic    reset_from_key,
   input  wire phase_t  phase,
   input  wire wave_e   wave_sel,
   output sample_t      carrier
);

   localparam int lut_depth = 1 << lut_addr_bits;

   sample_t sine_table [0:lut_depth-1];

   logic [lut_addr_bits-1:0] sin_addr;
   logic [lut_addr_bits-1:0] cos_addr;
   sample_t                  sin_val;
   sample_t                  cos_val;
   sample_t                  saw_val;
   sample_t                  square_val;
   sample_t                  carrier_q;

   initial
   begin
      $readmemh("hw/sine_lut.hex", sine_table);  // one full period
   end

   //////////////////// waveforms
   assign sin_addr = phase[31 -: lut_addr_bits];
   assign cos_addr = sin_addr + lut_addr_bits'(cos_offset);  // wraps in 6 bits

   assign sin_val    = sine_table[sin_addr];
   assign cos_val    = sine_table[cos_addr];
   assign saw_val    = sample_t'(phase[31:20]);                // top bits as signed
   assign square_val = phase[31] ? -full_scale : full_scale;

   //////////////////// carrier select
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         carrier_q <= '0;
      else
      begin
         case (wave_sel)
            wave_sin:    carrier_q <= sin_val;
            wave_cos:    carrier_q <= cos_val;
            wave_saw:    carrier_q <= saw_val;
            wave_square: carrier_q <= square_val;
            default:     carrier_q <= '0;
         endcase
      end
   end

   assign carrier = carrier_q;

endmodule

`default_nettype wire

// File: verif/tb_models.svh
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

//////////////////// random stimulus
// 32-bit fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] next_random_bits(input int count);
   logic [31:0] bits;
   logic        fb;
   int          i;
   bits = '0;
   for (i = 0; i < count; i++)
   begin
      fb         = rand_state[31] ^ rand_state[21] ^ rand_state[1] ^ rand_state[0];
      rand_state = {rand_state[30:0], fb};
      bits       = {bits[30:0], fb};  // one step per bit
   end
   return bits;
endfunction

//////////////////// reference models
// new bit from bit4 xor bit2 shifted in at bit 0
function automatic logic [4:0] symbol_lfsr_next(input logic [4:0] s);
   return {s[3:0], s[4] ^ s[2]};
endfunction

function automatic logic signed [11:0] carrier_model(input logic [31:0] ph,
                                                     input logic [1:0]  sel);
   logic [5:0] idx;
   logic [5:0] cos_idx;
   idx     = ph[31:26];
   cos_idx = idx + 6'd16;  // quarter period ahead
   case (sel)
      sel_sin: return sine_ref[idx];
      sel_cos: return sine_ref[cos_idx];
      sel_saw: return ph[31:20];
      default: return ph[31] ? -12'sd2047 : 12'sd2047;
   endcase
endfunction

function automatic logic signed [11:0] modulate_model(input logic [1:0]         mode,
                                                      input logic               d,
                                                      input logic signed [11:0] c);
   case (mode)
      sel_ask:  return d ? c : 12'sd0;
      sel_fsk:  return c;
      sel_bpsk: return d ? c : -c;
      default:  return d ? 12'sd2047 : -12'sd2047;
   endcase
endfunction

// one rising edge of the whole chain with the inputs as they stand now
task automatic model_advance();
   logic [31:0]        inc;
   logic signed [11:0] next_carrier;
   logic signed [11:0] next_mod;
   if (reset_from_key)
   begin
      m_phase   = '0;
      m_carrier = '0;
      m_mod     = '0;
      m_lfsr    = 5'b00001;
      m_mode    = sel_ask;
      m_tick    = 1'b0;
      m_edges   = 0;
   end
   else
   begin
      inc          = (m_mode == sel_fsk && m_lfsr[4]) ? freq_word << 1 : freq_word;
      next_carrier = carrier_model(m_phase, wave_sel);
      next_mod     = modulate_model(m_mode, m_lfsr[4], m_carrier);
      m_edges      = m_edges + 1;
      m_tick       = (m_edges % symbol_len == 0);
      if (m_tick)
         m_lfsr = symbol_lfsr_next(m_lfsr);
      m_phase   = m_phase + inc;
      m_carrier = next_carrier;
      m_mod     = next_mod;
      m_mode    = mod_sel;
   end
endtask

//////////////////// checking
task automatic check_value(input string test_name, input string what,
                           input logic [11:0] expected, input logic [11:0] actual);
   if (expected !== actual)
   begin
      $display("ERR %s %s: expected %0d, actual %0d", test_name, what,
               $signed(expected), $signed(actual));
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
   end
endtask

//////////////////// stimulus table
task automatic set_row(input int r, input string name, input logic [1:0] wave,
                       input logic [1:0] mode, input logic [31:0] freq, input int len);
   row_name[r] = name;
   row_wave[r] = wave;
   row_mod[r]  = mode;
   row_freq[r] = freq;
   row_len[r]  = len;
endtask

task automatic load_table();
   logic [31:0] k;
   int          total;
   int          r;
   $readmemh("hw/sine_lut.hex", sine_ref);
   k = next_random_bits(8) | 32'd1;  // forced odd so never zero
   set_row(0, "saw_ask", sel_saw, sel_ask, k << 20, 192);
   set_row(1, "sin_ask", sel_sin, sel_ask, 32'd1 << 26, 192);
   set_row(2, "cos_bpsk", sel_cos, sel_bpsk, 32'd1 << 26, 192);
   set_row(3, "square_lfsr", sel_square, sel_lfsr, 32'd1 << 26, 192);
   k = next_random_bits(8) | 32'd1;
   set_row(4, "saw_fsk", sel_saw, sel_fsk, k << 20, 256);
   k = next_random_bits(8) | 32'd1;
   set_row(5, "sin_bpsk", sel_sin, sel_bpsk, k << 20, 192);
   k = next_random_bits(8) | 32'd1;
   set_row(6, "saw_lfsr", sel_saw, sel_lfsr, k << 20, 160);
   total = 0;
   for (r = 0; r < num_rows; r++)
      total = total + row_len[r];
   timeout_limit = total + row_slack * num_rows;
endtask

`endif

// File: verif/tb_dds_modulator.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dds_modulator;

   localparam int symbol_len   = 16;
   localparam int reset_cycles = 5;
   localparam int num_rows     = 7;
   localparam int row_slack    = 100;  // extra cycles allowed per row

   // carrier codes
   localparam logic [1:0] sel_sin    = 2'd0;
   localparam logic [1:0] sel_cos    = 2'd1;
   localparam logic [1:0] sel_saw    = 2'd2;
   localparam logic [1:0] sel_square = 2'd3;

   // modulation codes
   localparam logic [1:0] sel_ask  = 2'd0;
   localparam logic [1:0] sel_fsk  = 2'd1;
   localparam logic [1:0] sel_bpsk = 2'd2;
   localparam logic [1:0] sel_lfsr = 2'd3;

   logic        CLK_25MHZ = 1'b0;
   logic        reset_from_key;
   logic [31:0] freq_word;
   logic [1:0]  wave_sel;
   logic [1:0]  mod_sel;
   logic [11:0] carrier_out;
   logic [11:0] modulated_out;
   logic        data_bit;
   logic        symbol_tick;

   //////////////////// table
   string       row_name [num_rows];
   logic [1:0]  row_wave [num_rows];
   logic [1:0]  row_mod  [num_rows];
   logic [31:0] row_freq [num_rows];
   int          row_len  [num_rows];

   //////////////////// model state
   logic signed [11:0] sine_ref [0:63];
   logic [31:0]        rand_state = 32'ha56f;
   logic [31:0]        m_phase;
   logic signed [11:0] m_carrier;
   logic signed [11:0] m_mod;
   logic [4:0]         m_lfsr;
   logic [1:0]         m_mode;
   logic               m_tick;
   int                 m_edges;

   int cycle_count   = 0;
   int timeout_limit = 0;

   `include "tb_models.svh"

   always #20 CLK_25MHZ = ~CLK_25MHZ;  // 25 MHz

   dds_modulator_top #(
      .symbol_cycles (symbol_len)
   ) dds_modulator_top_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .freq_word      (freq_word),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .carrier_out    (carrier_out),
      .modulated_out  (modulated_out),
      .data_bit       (data_bit),
      .symbol_tick    (symbol_tick)
   );

   // run budget from the table lengths
   always @(posedge CLK_25MHZ)
   begin
      cycle_count <= cycle_count + 1;
      if (timeout_limit > 0 && cycle_count >= timeout_limit)
      begin
         $display("simulation timed out after %0d cycles", cycle_count);
         $display("TEST FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   // reset the DUT and compare every cycle against the models
   task automatic run_row(input int r);
      reset_from_key = 1'b1;
      wave_sel       = row_wave[r];
      mod_sel        = row_mod[r];
      freq_word      = row_freq[r];
      repeat (reset_cycles)
      begin
         @(negedge CLK_25MHZ);
         model_advance();
      end
      check_value(row_name[r], "reset carrier_out", 12'd0, carrier_out);
      check_value(row_name[r], "reset modulated_out", 12'd0, modulated_out);
      check_value(row_name[r], "reset symbol_tick", 12'd0, {11'd0, symbol_tick});
      check_value(row_name[r], "reset data_bit", 12'd0, {11'd0, data_bit});
      reset_from_key = 1'b0;
      repeat (row_len[r])
      begin
         @(negedge CLK_25MHZ);  // outputs settled since the rising edge
         model_advance();
         check_value(row_name[r], "carrier_out", m_carrier, carrier_out);
         check_value(row_name[r], "modulated_out", m_mod, modulated_out);
         check_value(row_name[r], "symbol_tick", {11'd0, m_tick}, {11'd0, symbol_tick});
         check_value(row_name[r], "data_bit", {11'd0, m_lfsr[4]}, {11'd0, data_bit});
      end
   endtask

   initial
   begin
      int r;
      reset_from_key = 1'b1;
      freq_word      = '0;
      wave_sel       = '0;
      mod_sel        = '0;
      load_table();
      for (r = 0; r < num_rows; r++)
         run_row(r);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire
